/* verilog.f */
+incdir+hdl
+incdir+bench
hdl/dct_pkg.sv
hdl/dct_ctrl_if.sv
hdl/dct_col_ctrl.sv
hdl/dct_fold_stage.sv
hdl/dct_even_part.sv
hdl/dct_odd_part.sv
hdl/dct_col_round.sv
hdl/dct16_col_top.sv
bench/dct_col_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the column DCT testbench with Verilator, run it and judge the run from its log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module dct_col_tb \
    && ./obj_dir/Vdct_col_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation stopped with an error"; exit 1; }
cat sim.log
grep -q "Regression failed" sim.log && exit 1 || grep -q "Regression passed" sim.log

/* bench/dct_model.svh */
// reference model of the column DCT built from the cosine-index rule, included inside the testbench
`ifndef DCT_MODEL_SVH
`define DCT_MODEL_SVH

// scaled cosine magnitude of angle step m, m in 0..16
function automatic int cos_mag(input int m);
    int tbl [0:16];
    tbl = '{`DCT_C0, `DCT_C1, `DCT_C2, `DCT_C3, `DCT_C4, `DCT_C5, `DCT_C6, `DCT_C7,
            `DCT_C8, `DCT_C9, `DCT_C10, `DCT_C11, `DCT_C12, `DCT_C13, `DCT_C14,
            `DCT_C15, `DCT_C16};
    return tbl[m];
endfunction

// signed weight of sample n in coefficient k
function automatic int cos_weight(input int k, input int n);
    int m;
    m = ((2 * n + 1) * k) % 64;
    // fold the angle into the first half turn
    if (m > 32) begin
        m = 64 - m;
    end
    // past a quarter turn the cosine goes negative
    if (m > 16) begin
        return -cos_mag(32 - m);
    end
    return cos_mag(m);
endfunction

// expected coefficient k of one column
function automatic dct_pkg::coef_t model_coef(input dct_pkg::sample_t [0:`DCT_N-1] xs,
                                              input int k, input logic bflag);
    int                    acc;
    int                    dc_sh;
    logic [`DCT_SUM_W-1:0] s;
    dct_pkg::coef_t        cut;
    acc = 0;
    for (int n = 0; n < `DCT_N; n++) begin
        acc = acc + cos_weight(k, n) * int'($signed(xs[n]));
    end
    // exact sum wrapped to the datapath width
    s = acc[`DCT_SUM_W-1:0];
    if (k == 0) begin
        // all weights are C0, so acc / C0 is the plain DC sum
        dc_sh = bflag ? ((acc / `DCT_C0) >>> 3) : ((acc / `DCT_C0) >>> 1);
        cut   = dc_sh[`DCT_OUT_W-1:0];
        // field sign against the sign of the full DC sum
        if (cut[`DCT_OUT_W-1] != (acc < 0)) begin
            cut = ~cut;
        end
    end else begin
        cut = s[`DCT_CUT_HI:`DCT_CUT_LO];
        // X1 gets the same sign repair against its exact sum
        if (k == 1 && cut[`DCT_OUT_W-1] != s[`DCT_SUM_W-1]) begin
            cut = ~cut;
        end
    end
    return cut;
endfunction

`endif

/* bench/dct_col_tb.sv */
// testbench of the 16-point column DCT, random, corner and impulse columns checked against a model
`timescale 1ns/10ps
`default_nettype none
`include "dct_defs.svh"

module dct_col_tb;

    `include "dct_model.svh"

    localparam int RST_CYCLES  = 16;
    localparam int IDLE_CYCLES = 8;
    localparam int N_ISO       = 200;
    localparam int N_B2B       = 200;
    localparam int N_CORNER    = 6;
    // isolated column costs a drive cycle, a gap and the drain
    localparam int ISO_CYCLES  = 8;
    localparam int DRAIN_LIMIT = 10;
    localparam int MAX_CYCLES  = RST_CYCLES + IDLE_CYCLES + N_B2B
                               + (N_ISO + N_CORNER + `DCT_N) * ISO_CYCLES + 40;
    // extreme sample values
    localparam dct_pkg::sample_t S_MAX = {1'b0, {(`DCT_IN_W-1){1'b1}}};
    localparam dct_pkg::sample_t S_MIN = {1'b1, {(`DCT_IN_W-1){1'b0}}};

    logic                          clk;
    logic                          arst_n;
    logic                          in_valid;
    logic                          block_flag;
    dct_pkg::sample_t [0:`DCT_N-1] x_in;
    wire                           out_valid;
    wire dct_pkg::coef_t [0:`DCT_N-1] x_out;

    integer seed;
    int     cycle;
    int     errors;
    int     checks;
    int     tests;
    int     in_count;
    int     out_count;
    // expected columns and the cycle each one entered
    dct_pkg::coef_t [0:`DCT_N-1] exp_q [$];
    int                          in_cyc_q [$];
    dct_pkg::coef_t [0:`DCT_N-1] exp_col;

    dct16_col_top dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .block_flag (block_flag),
        .x_in       (x_in),
        .out_valid  (out_valid),
        .x_out      (x_out)
    );

    // 10 ns clock
    always #5 clk = ~clk;

    task automatic check_coef(input int idx, input dct_pkg::coef_t got, input dct_pkg::coef_t exp);
        checks = checks + 1;
        if (got !== exp) begin
            $display("ERROR: %0t ns: x_out[%0d] got %0d expected %0d", $time, idx, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic check_valid(input string name, input int got, input int exp);
        checks = checks + 1;
        if (got != exp) begin
            $display("ERROR: %0t ns: %s got %0d expected %0d", $time, name, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic random_column(output dct_pkg::sample_t [0:`DCT_N-1] xs);
        for (int n = 0; n < `DCT_N; n++) begin
            xs[n] = dct_pkg::sample_t'($random(seed));
        end
    endtask

    // queue the model result, then present the column on the next edge
    task automatic drive_column(input dct_pkg::sample_t [0:`DCT_N-1] xs, input logic bflag);
        dct_pkg::coef_t [0:`DCT_N-1] col;
        for (int k = 0; k < `DCT_N; k++) begin
            col[k] = model_coef(xs, k, bflag);
        end
        exp_q.push_back(col);
        @(posedge clk);
        in_valid   <= 1'b1;
        block_flag <= bflag;
        x_in       <= xs;
    endtask

    // drop in_valid after the last column of a burst
    task automatic end_burst();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    // wait until every queued column has come out
    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited = waited + 1;
        end
        if (exp_q.size() != 0) begin
            $display("ERROR: %0t ns: %0d columns never came out", $time, exp_q.size());
            errors = errors + 1;
            exp_q.delete();
            in_cyc_q.delete();
        end
    endtask

    task automatic report_test(input string name, input int err0);
        tests = tests + 1;
        $display("test %0d %s: %0d errors", tests, name, errors - err0);
    endtask

    // scoreboard and watchdog, one process so cycle stays consistent
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (arst_n) begin
            if (in_valid) begin
                in_cyc_q.push_back(cycle);
                in_count = in_count + 1;
            end
            if (out_valid) begin
                out_count = out_count + 1;
                if (exp_q.size() == 0 || in_cyc_q.size() == 0) begin
                    $display("ERROR: %0t ns: out_valid pulse with no column in flight", $time);
                    errors = errors + 1;
                end else begin
                    exp_col = exp_q.pop_front();
                    for (int k = 0; k < `DCT_N; k++) begin
                        check_coef(k, x_out[k], exp_col[k]);
                    end
                    check_valid("out_valid latency", cycle - in_cyc_q.pop_front(), 3);
                end
            end
        end
        if (cycle >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycle);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        dct_pkg::sample_t [0:`DCT_N-1] xs;
        int err0;
        int in0;
        int out0;
        seed       = 14;
        cycle      = 0;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        in_count   = 0;
        out_count  = 0;
        clk        = 1'b0;
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        block_flag = 1'b0;
        x_in       = '0;
        repeat (RST_CYCLES) @(posedge clk);
        arst_n <= 1'b1;

        // quiet outputs before any column
        err0 = errors;
        repeat (IDLE_CYCLES) begin
            @(posedge clk);
            check_valid("out_valid", int'(out_valid), 0);
            for (int k = 0; k < `DCT_N; k++) begin
                check_coef(k, x_out[k], '0);
            end
        end
        report_test("idle after reset", err0);

        err0 = errors;
        repeat (N_ISO) begin
            random_column(xs);
            drive_column(xs, 1'b0);
            end_burst();
            wait_drain();
        end
        report_test("isolated random columns", err0);

        // three columns in flight, block_flag changes per column
        err0 = errors;
        in0  = in_count;
        out0 = out_count;
        repeat (N_B2B) begin
            random_column(xs);
            drive_column(xs, 1'($random(seed)));
        end
        end_burst();
        wait_drain();
        check_valid("out_valid pulses", out_count - out0, in_count - in0);
        report_test("back-to-back random columns", err0);

        // full scale, lowest scale and alternating signs, with both flag levels
        err0 = errors;
        for (int c = 0; c < N_CORNER; c++) begin
            for (int n = 0; n < `DCT_N; n++) begin
                case (c % 3)
                    0:       xs[n] = S_MAX;
                    1:       xs[n] = S_MIN;
                    default: xs[n] = n[0] ? S_MIN : S_MAX;
                endcase
            end
            drive_column(xs, 1'(c >= 3));
            end_burst();
            wait_drain();
        end
        report_test("corner columns", err0);

        // impulse at each position shows every weight sign
        err0 = errors;
        for (int p = 0; p < `DCT_N; p++) begin
            xs    = '0;
            xs[p] = S_MAX;
            drive_column(xs, 1'b0);
            end_burst();
            wait_drain();
        end
        report_test("impulse columns", err0);

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/dct16_col_top.sv */
// 16-point column DCT top, three-stage pipeline from x_in and in_valid to x_out and out_valid
`timescale 1ns/10ps
`default_nettype none
`include "dct_defs.svh"

module dct16_col_top (
    input  wire                                clk,
    input  wire                                arst_n,
    input  wire                                in_valid,
    input  wire                                block_flag,
    // sample 0 in the top bits
    input  wire dct_pkg::sample_t [0:`DCT_N-1] x_in,
    output wire                                out_valid,
    // X0 in the top bits
    output wire dct_pkg::coef_t [0:`DCT_N-1]   x_out
);

    // stage buses
    wire dct_pkg::fold_t      fold;
    wire dct_pkg::even_sums_t even;
    wire dct_pkg::odd_sums_t  odd;

    dct_ctrl_if ctl_if ();

    // valid chain and stage enables
    dct_col_ctrl u_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .block_flag (block_flag),
        .ctl        (ctl_if.ctrl),
        .out_valid  (out_valid)
    );

    dct_fold_stage u_fold (
        .clk    (clk),
        .arst_n (arst_n),
        .ctl    (ctl_if.stage),
        .x_in   (x_in),
        .fold   (fold)
    );

    // even and odd halves run side by side
    dct_even_part u_even (
        .clk    (clk),
        .arst_n (arst_n),
        .ctl    (ctl_if.stage),
        .fold   (fold),
        .even   (even)
    );

    dct_odd_part u_odd (
        .clk    (clk),
        .arst_n (arst_n),
        .ctl    (ctl_if.stage),
        .fold   (fold),
        .odd    (odd)
    );

    dct_col_round u_round (
        .clk    (clk),
        .arst_n (arst_n),
        .ctl    (ctl_if.stage),
        .even   (even),
        .odd    (odd),
        .x_out  (x_out)
    );

endmodule

`default_nettype wire

/* hdl/dct_col_round.sv */
// output stage of the column DCT, cuts each 12-bit coefficient and registers x_out on round_en
`timescale 1ns/10ps
`default_nettype none
`include "dct_defs.svh"

module dct_col_round (
    input  wire                               clk,
    input  wire                               arst_n,
    dct_ctrl_if.stage                         ctl,
    input  wire dct_pkg::even_sums_t          even,
    input  wire dct_pkg::odd_sums_t           odd,
    output dct_pkg::coef_t [0:`DCT_N-1]       x_out
);

    dct_pkg::dc_t                  dc_sh;
    dct_pkg::coef_t                x0_cut;
    dct_pkg::coef_t                x1_cut;
    dct_pkg::sum_t                 nyq_w;
    dct_pkg::coef_t [0:`DCT_N-1]   x_d;

    always_comb begin
        // block columns scale DC down by 8, otherwise by 2
        dc_sh  = ctl.round_block_flag ? (even.dc >>> 3) : (even.dc >>> 1);
        x0_cut = dc_sh[`DCT_OUT_W-1:0];
        x1_cut = odd.x1[`DCT_CUT_HI:`DCT_CUT_LO];
        // Nyquist term carries C8 = 16
        nyq_w  = even.nyq <<< 4;

        // field sign disagrees with the full sum, flip all bits
        x_d[0]  = (x0_cut[`DCT_OUT_W-1] != even.dc[$bits(dct_pkg::dc_t)-1]) ? ~x0_cut : x0_cut;
        x_d[1]  = (x1_cut[`DCT_OUT_W-1] != odd.x1[`DCT_SUM_W-1]) ? ~x1_cut : x1_cut;
        x_d[2]  = even.x2[`DCT_CUT_HI:`DCT_CUT_LO];
        x_d[3]  = odd.x3[`DCT_CUT_HI:`DCT_CUT_LO];
        x_d[4]  = even.x4[`DCT_CUT_HI:`DCT_CUT_LO];
        x_d[5]  = odd.x5[`DCT_CUT_HI:`DCT_CUT_LO];
        x_d[6]  = even.x6[`DCT_CUT_HI:`DCT_CUT_LO];
        x_d[7]  = odd.x7[`DCT_CUT_HI:`DCT_CUT_LO];
        x_d[8]  = nyq_w[`DCT_CUT_HI:`DCT_CUT_LO];
        x_d[9]  = odd.x9[`DCT_CUT_HI:`DCT_CUT_LO];
        x_d[10] = even.x10[`DCT_CUT_HI:`DCT_CUT_LO];
        x_d[11] = odd.x11[`DCT_CUT_HI:`DCT_CUT_LO];
        x_d[12] = even.x12[`DCT_CUT_HI:`DCT_CUT_LO];
        x_d[13] = odd.x13[`DCT_CUT_HI:`DCT_CUT_LO];
        x_d[14] = even.x14[`DCT_CUT_HI:`DCT_CUT_LO];
        x_d[15] = odd.x15[`DCT_CUT_HI:`DCT_CUT_LO];
    end

    // x_out holds between columns
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            x_out <= '0;
        end else if (ctl.round_en) begin
            x_out <= x_d;
        end
    end

endmodule

`default_nettype wire

/* hdl/dct_odd_part.sv */
// odd-index half of the column DCT, eight shift-and-add sums of the differences on mult_en
`timescale 1ns/10ps
`default_nettype none
`include "dct_defs.svh"

module dct_odd_part (
    input  wire                 clk,
    input  wire                 arst_n,
    dct_ctrl_if.stage           ctl,
    input  wire dct_pkg::fold_t fold,
    output dct_pkg::odd_sums_t  odd
);

    // in-range samples differ by at most 2^11-1, one coefficient total below the type bound
    localparam int odd_limit = `DCT_ODD_PEAK - (`DCT_ODD_PEAK >> `DCT_IN_W);

    // acc[i] is the exact sum for X(2i+1)
    dct_pkg::sum_t acc [0:`DCT_N/2-1];

    // X1 uses every odd magnitude in falling order, all positive
    assign acc[0] = dct_pkg::cmul(fold.dif[0], `DCT_C1) + dct_pkg::cmul(fold.dif[1], `DCT_C3)
                  + dct_pkg::cmul(fold.dif[2], `DCT_C5) + dct_pkg::cmul(fold.dif[3], `DCT_C7)
                  + dct_pkg::cmul(fold.dif[4], `DCT_C9) + dct_pkg::cmul(fold.dif[5], `DCT_C11)
                  + dct_pkg::cmul(fold.dif[6], `DCT_C13) + dct_pkg::cmul(fold.dif[7], `DCT_C15);
    assign acc[1] = dct_pkg::cmul(fold.dif[0], `DCT_C3) + dct_pkg::cmul(fold.dif[1], `DCT_C9)
                  + dct_pkg::cmul(fold.dif[2], `DCT_C15) - dct_pkg::cmul(fold.dif[3], `DCT_C11)
                  - dct_pkg::cmul(fold.dif[4], `DCT_C5) - dct_pkg::cmul(fold.dif[5], `DCT_C1)
                  - dct_pkg::cmul(fold.dif[6], `DCT_C7) - dct_pkg::cmul(fold.dif[7], `DCT_C13);
    assign acc[2] = dct_pkg::cmul(fold.dif[0], `DCT_C5) + dct_pkg::cmul(fold.dif[1], `DCT_C15)
                  - dct_pkg::cmul(fold.dif[2], `DCT_C7) - dct_pkg::cmul(fold.dif[3], `DCT_C3)
                  - dct_pkg::cmul(fold.dif[4], `DCT_C13) + dct_pkg::cmul(fold.dif[5], `DCT_C9)
                  + dct_pkg::cmul(fold.dif[6], `DCT_C1) + dct_pkg::cmul(fold.dif[7], `DCT_C11);
    assign acc[3] = dct_pkg::cmul(fold.dif[0], `DCT_C7) - dct_pkg::cmul(fold.dif[1], `DCT_C11)
                  - dct_pkg::cmul(fold.dif[2], `DCT_C3) + dct_pkg::cmul(fold.dif[3], `DCT_C15)
                  + dct_pkg::cmul(fold.dif[4], `DCT_C1) + dct_pkg::cmul(fold.dif[5], `DCT_C13)
                  - dct_pkg::cmul(fold.dif[6], `DCT_C5) - dct_pkg::cmul(fold.dif[7], `DCT_C9);
    assign acc[4] = dct_pkg::cmul(fold.dif[0], `DCT_C9) - dct_pkg::cmul(fold.dif[1], `DCT_C5)
                  - dct_pkg::cmul(fold.dif[2], `DCT_C13) + dct_pkg::cmul(fold.dif[3], `DCT_C1)
                  - dct_pkg::cmul(fold.dif[4], `DCT_C15) - dct_pkg::cmul(fold.dif[5], `DCT_C3)
                  + dct_pkg::cmul(fold.dif[6], `DCT_C11) + dct_pkg::cmul(fold.dif[7], `DCT_C7);
    assign acc[5] = dct_pkg::cmul(fold.dif[0], `DCT_C11) - dct_pkg::cmul(fold.dif[1], `DCT_C1)
                  + dct_pkg::cmul(fold.dif[2], `DCT_C9) + dct_pkg::cmul(fold.dif[3], `DCT_C13)
                  - dct_pkg::cmul(fold.dif[4], `DCT_C3) + dct_pkg::cmul(fold.dif[5], `DCT_C7)
                  + dct_pkg::cmul(fold.dif[6], `DCT_C15) - dct_pkg::cmul(fold.dif[7], `DCT_C5);
    assign acc[6] = dct_pkg::cmul(fold.dif[0], `DCT_C13) - dct_pkg::cmul(fold.dif[1], `DCT_C7)
                  + dct_pkg::cmul(fold.dif[2], `DCT_C1) - dct_pkg::cmul(fold.dif[3], `DCT_C5)
                  + dct_pkg::cmul(fold.dif[4], `DCT_C11) + dct_pkg::cmul(fold.dif[5], `DCT_C15)
                  - dct_pkg::cmul(fold.dif[6], `DCT_C9) + dct_pkg::cmul(fold.dif[7], `DCT_C3);
    // X15 alternates sign on rising magnitudes
    assign acc[7] = dct_pkg::cmul(fold.dif[0], `DCT_C15) - dct_pkg::cmul(fold.dif[1], `DCT_C13)
                  + dct_pkg::cmul(fold.dif[2], `DCT_C11) - dct_pkg::cmul(fold.dif[3], `DCT_C9)
                  + dct_pkg::cmul(fold.dif[4], `DCT_C7) - dct_pkg::cmul(fold.dif[5], `DCT_C5)
                  + dct_pkg::cmul(fold.dif[6], `DCT_C3) - dct_pkg::cmul(fold.dif[7], `DCT_C1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            odd <= '0;
        end else if (ctl.mult_en) begin
            odd <= '{x1: acc[0], x3: acc[1], x5: acc[2], x7: acc[3],
                     x9: acc[4], x11: acc[5], x13: acc[6], x15: acc[7]};
        end
    end

    // fold differences of in-range samples keep every sum inside the peak magnitude
    for (genvar i = 0; i < `DCT_N / 2; i++) begin : g_range
        a_odd_range: assert property (@(posedge clk) disable iff (!arst_n)
            ctl.mult_en |-> (acc[i] <= odd_limit) && (acc[i] >= -odd_limit));
    end

endmodule

`default_nettype wire

/* hdl/dct_even_part.sv */
// even-index half of the column DCT, butterflies and shift-and-add products registered on mult_en
`timescale 1ns/10ps
`default_nettype none
`include "dct_defs.svh"

module dct_even_part (
    input  wire                 clk,
    input  wire                 arst_n,
    dct_ctrl_if.stage           ctl,
    input  wire dct_pkg::fold_t fold,
    output dct_pkg::even_sums_t even
);

    // second butterfly level, 13 bits
    logic signed [`DCT_IN_W+1:0] a0, a1, a2, a3;
    logic signed [`DCT_IN_W+1:0] d0, d1, d2, d3;
    // third level, 14 bits
    logic signed [`DCT_IN_W+2:0] e1, e2, e3, e4;
    // full Nyquist sum, only its low bits survive the cut
    dct_pkg::dc_t nyq_full;
    dct_pkg::even_sums_t even_d;

    // pair the mirrored sums again, k with 7-k
    assign a0 = fold.sum[0] + fold.sum[7];
    assign a1 = fold.sum[1] + fold.sum[6];
    assign a2 = fold.sum[2] + fold.sum[5];
    assign a3 = fold.sum[3] + fold.sum[4];
    assign d0 = fold.sum[0] - fold.sum[7];
    assign d1 = fold.sum[1] - fold.sum[6];
    assign d2 = fold.sum[2] - fold.sum[5];
    assign d3 = fold.sum[3] - fold.sum[4];

    // outer pair a0/a3 and inner pair a1/a2
    assign e1 = a0 + a3;
    assign e3 = a0 - a3;
    assign e2 = a1 + a2;
    assign e4 = a1 - a2;

    assign nyq_full = e1 - e2;

    always_comb begin
        // DC is the plain sum of all sixteen samples
        even_d.dc  = e1 + e2;
        even_d.nyq = nyq_full[`DCT_CUT_HI-4:0];
        // X4 and X12 rotate e3/e4 by C4 and C12
        even_d.x4  = dct_pkg::cmul(e3, `DCT_C4) + dct_pkg::cmul(e4, `DCT_C12);
        even_d.x12 = dct_pkg::cmul(e3, `DCT_C12) - dct_pkg::cmul(e4, `DCT_C4);
        // X2, X6, X10, X14 weight the four level-two differences
        even_d.x2  = dct_pkg::cmul(d0, `DCT_C2) + dct_pkg::cmul(d1, `DCT_C6)
                   + dct_pkg::cmul(d2, `DCT_C10) + dct_pkg::cmul(d3, `DCT_C14);
        even_d.x6  = dct_pkg::cmul(d0, `DCT_C6) - dct_pkg::cmul(d1, `DCT_C14)
                   - dct_pkg::cmul(d2, `DCT_C2) - dct_pkg::cmul(d3, `DCT_C10);
        even_d.x10 = dct_pkg::cmul(d0, `DCT_C10) - dct_pkg::cmul(d1, `DCT_C2)
                   + dct_pkg::cmul(d2, `DCT_C14) + dct_pkg::cmul(d3, `DCT_C6);
        even_d.x14 = dct_pkg::cmul(d0, `DCT_C14) - dct_pkg::cmul(d1, `DCT_C10)
                   + dct_pkg::cmul(d2, `DCT_C6) - dct_pkg::cmul(d3, `DCT_C2);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            even <= '0;
        end else if (ctl.mult_en) begin
            even <= even_d;
        end
    end

endmodule

`default_nettype wire

/* hdl/dct_fold_stage.sv */
// first butterfly of the column DCT, registers mirrored sums and differences on fold_en
`timescale 1ns/10ps
`default_nettype none
`include "dct_defs.svh"

module dct_fold_stage (
    input  wire                                clk,
    input  wire                                arst_n,
    dct_ctrl_if.stage                          ctl,
    input  wire dct_pkg::sample_t [0:`DCT_N-1] x_in,
    output dct_pkg::fold_t                     fold
);

    dct_pkg::fold_t fold_d;

    // sample j against its mirror 15-j, 11 bits grow to 12
    always_comb begin
        for (int j = 0; j < `DCT_N / 2; j++) begin
            fold_d.sum[j] = x_in[j] + x_in[`DCT_N-1-j];
            fold_d.dif[j] = x_in[j] - x_in[`DCT_N-1-j];
        end
    end

    // load only on the column's own pulse
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fold <= '0;
        end else if (ctl.fold_en) begin
            fold <= fold_d;
        end
    end

endmodule

`default_nettype wire

/* hdl/dct_col_ctrl.sv */
// valid pipeline of the column DCT, makes one enable pulse per stage and tracks block_flag
`timescale 1ns/10ps
`default_nettype none

module dct_col_ctrl (
    input  wire        clk,
    input  wire        arst_n,
    input  wire        in_valid,
    input  wire        block_flag,
    dct_ctrl_if.ctrl   ctl,
    output logic       out_valid
);

    // vld_q[n] is in_valid delayed by n cycles
    logic [3:1] vld_q;
    // block_flag rides two cycles behind, lined up with round_en
    logic [2:1] bf_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_q <= '0;
            bf_q  <= '0;
        end else begin
            vld_q <= {vld_q[2:1], in_valid};
            bf_q  <= {bf_q[1], block_flag};
        end
    end

    // fold stage samples x_in on the same edge as in_valid
    assign ctl.fold_en          = in_valid;
    assign ctl.mult_en          = vld_q[1];
    assign ctl.round_en         = vld_q[2];
    assign ctl.round_block_flag = bf_q[2];
    // x_out is loaded on round_en, so it is valid one cycle later
    assign out_valid            = vld_q[3];

    // every accepted column comes out three cycles later
    a_out_latency: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid |-> ##3 out_valid);

    // rounding only ever follows a product stage load
    a_round_after_mult: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(ctl.round_en) |-> $past(ctl.mult_en));

endmodule

`default_nettype wire

/* hdl/dct_ctrl_if.sv */
// stage enables and the delayed block flag, driven by the control block into the datapath stages
`timescale 1ns/10ps
`default_nettype none

interface dct_ctrl_if;

    // fold registers on the in_valid edge
    logic fold_en;
    // even and odd parts one cycle later
    logic mult_en;
    // rounding one cycle after that
    logic round_en;
    // block_flag of the column now in rounding
    logic round_block_flag;

    modport ctrl (
        output fold_en,
        output mult_en,
        output round_en,
        output round_block_flag
    );

    modport stage (
        input fold_en,
        input mult_en,
        input round_en,
        input round_block_flag
    );

endinterface

`default_nettype wire

/* hdl/dct_pkg.sv */
// datapath types and the constant multiply of the column DCT, referenced as dct_pkg::name
`default_nettype none
`include "dct_defs.svh"

package dct_pkg;

    // one input sample
    typedef logic signed [`DCT_IN_W-1:0] sample_t;
    // mirrored sum or difference, one bit of growth
    typedef logic signed [`DCT_IN_W:0] fold_w_t;
    // full 16-sample DC sum and the low part of the Nyquist sum
    typedef logic signed [`DCT_IN_W+3:0] dc_t;
    typedef logic signed [`DCT_CUT_HI-4:0] nyq_t;
    // exact shift-and-add product sum
    typedef logic signed [`DCT_SUM_W-1:0] sum_t;
    // one output coefficient
    typedef logic signed [`DCT_OUT_W-1:0] coef_t;

    // first butterfly, index j pairs sample j with sample 15-j
    typedef struct packed {
        fold_w_t [0:`DCT_N/2-1] sum;
        fold_w_t [0:`DCT_N/2-1] dif;
    } fold_t;

    typedef struct packed {
        dc_t  dc;
        nyq_t nyq;
        sum_t x2, x4, x6, x10, x12, x14;
    } even_sums_t;

    typedef struct packed {
        sum_t x1, x3, x5, x7, x9, x11, x13, x15;
    } odd_sums_t;

    // constant multiply, one shifted copy per set coefficient bit
    function automatic sum_t cmul(input sum_t v, input int c);
        sum_t acc;
        acc = '0;
        for (int b = 0; b < `DCT_COEF_W; b++) begin
            if (c[b]) begin
                acc = acc + (v <<< b);
            end
        end
        return acc;
    endfunction

endpackage

`default_nettype wire

/* hdl/dct_defs.svh */
// widths, cut positions and cosine constants of the 16-point column DCT, included wherever needed
`ifndef DCT_DEFS_SVH
`define DCT_DEFS_SVH

// number format
`define DCT_N        16
`define DCT_IN_W     11
`define DCT_OUT_W    12
`define DCT_SUM_W    23
// kept field of each exact sum
`define DCT_CUT_HI   16
`define DCT_CUT_LO   5
// coefficient magnitudes fit in this many bits
`define DCT_COEF_W   5

// cosine magnitudes scaled by 2^5, index is the cosine angle step
`define DCT_C0       16
`define DCT_C1       23
`define DCT_C2       22
`define DCT_C3       22
`define DCT_C4       21
`define DCT_C5       20
`define DCT_C6       19
`define DCT_C7       17
`define DCT_C8       16
`define DCT_C9       14
`define DCT_C10      13
`define DCT_C11      11
`define DCT_C12      9
`define DCT_C13      7
`define DCT_C14      4
`define DCT_C15      2
`define DCT_C16      0

// largest odd sum magnitude, odd coefficients summed times the widest difference
`define DCT_ODD_PEAK ((`DCT_C1 + `DCT_C3 + `DCT_C5 + `DCT_C7 + `DCT_C9 + `DCT_C11 \
                      + `DCT_C13 + `DCT_C15) << `DCT_IN_W)

`endif
